//--- design/state_pkg.sv
`default_nettype none

package state_pkg;

    // Word widths, equal for every kept element type
    localparam int STATE_WID  = 16;
    localparam int UPDATE_WID = 16;

    typedef logic [STATE_WID-1:0]  state_t;
    typedef logic [UPDATE_WID-1:0] update_t;

    // Element behavior on datapath updates
    typedef enum logic [1:0] {
        ELEMENT_TYPE_WRITE   = 2'd0,
        ELEMENT_TYPE_FLAGS   = 2'd1,
        ELEMENT_TYPE_COUNTER = 2'd2,
        ELEMENT_TYPE_COUNT   = 2'd3
    } element_type_e;

    // State left behind after a reap
    typedef enum logic [1:0] {
        REAP_MODE_CLEAR   = 2'd0,
        REAP_MODE_PERSIST = 2'd1,
        REAP_MODE_UPDATE  = 2'd2
    } reap_mode_e;

    // Value reported back to the requester
    typedef enum logic [1:0] {
        RETURN_MODE_PREV_STATE = 2'd0,
        RETURN_MODE_NEXT_STATE = 2'd1,
        RETURN_MODE_DELTA      = 2'd2
    } return_mode_e;

    // Kind of operation, NONE is a plain read
    typedef enum logic [1:0] {
        UPDATE_CTXT_NONE     = 2'd0,
        UPDATE_CTXT_DATAPATH = 2'd1,
        UPDATE_CTXT_CONTROL  = 2'd2,
        UPDATE_CTXT_REAP     = 2'd3
    } update_ctxt_e;

endpackage : state_pkg

`default_nettype wire

//--- design/table_pkg.sv
`default_nettype none

package table_pkg;

    // Table geometry
    localparam int FLOW_ID_WID = 8;
    localparam int NUM_FLOWS   = 1 << FLOW_ID_WID;

    typedef logic [FLOW_ID_WID-1:0] flow_id_t;

    // Requester of an operation
    typedef enum logic {
        SRC_DATAPATH = 1'b0,
        SRC_CONTROL  = 1'b1
    } src_e;

    // APB bus
    localparam int APB_ADDR_WID = 12;
    localparam int APB_DATA_WID = 32;

    typedef logic [APB_ADDR_WID-1:0] apb_addr_t;
    typedef logic [APB_DATA_WID-1:0] apb_data_t;

    // Address map: region in bits 11:10, flow id in bits 9:2
    localparam int APB_ID_LSB     = 2;
    localparam int APB_REGION_LSB = 10;

    typedef logic [1:0] apb_region_t;

    localparam apb_region_t APB_REGION_STATE = 2'd0;
    localparam apb_region_t APB_REGION_REAP  = 2'd1;

endpackage : table_pkg

`default_nettype wire

//--- design/state_element.sv
`default_nettype none

module state_element #(
    parameter state_pkg::element_type_e ELEMENT_TYPE = state_pkg::ELEMENT_TYPE_COUNT,
    parameter state_pkg::reap_mode_e    REAP_MODE    = state_pkg::REAP_MODE_CLEAR,
    parameter state_pkg::return_mode_e  RETURN_MODE  = state_pkg::RETURN_MODE_DELTA
) (
    input  state_pkg::update_ctxt_e ctxt,
    input  state_pkg::state_t       prev_state,
    input  state_pkg::update_t      update,
    input  logic                    init,
    output state_pkg::state_t       next_state,
    output state_pkg::state_t       return_state
);

    state_pkg::state_t upd_state;
    state_pkg::state_t dp_state;
    state_pkg::state_t reap_state;

    assign upd_state = state_pkg::state_t'(update);

    // Datapath update, selected by element type
    always_comb begin
        case (ELEMENT_TYPE)
            state_pkg::ELEMENT_TYPE_WRITE:
                dp_state = upd_state;
            state_pkg::ELEMENT_TYPE_FLAGS:
                dp_state = init ? upd_state : (prev_state | upd_state);
            state_pkg::ELEMENT_TYPE_COUNTER:
                dp_state = init ? state_pkg::state_t'(1) : prev_state + 1'b1;
            state_pkg::ELEMENT_TYPE_COUNT:
                dp_state = init ? upd_state : prev_state + upd_state;
            default:
                dp_state = prev_state;
        endcase
    end

    // Reap result
    always_comb begin
        case (REAP_MODE)
            state_pkg::REAP_MODE_CLEAR:   reap_state = '0;
            state_pkg::REAP_MODE_PERSIST: reap_state = prev_state;
            state_pkg::REAP_MODE_UPDATE:  reap_state = upd_state;
            default:                      reap_state = prev_state;
        endcase
    end

    // Control overwrites regardless of element type
    always_comb begin
        case (ctxt)
            state_pkg::UPDATE_CTXT_DATAPATH: next_state = dp_state;
            state_pkg::UPDATE_CTXT_CONTROL:  next_state = upd_state;
            state_pkg::UPDATE_CTXT_REAP:     next_state = reap_state;
            default:                         next_state = prev_state;
        endcase
    end

    always_comb begin
        case (RETURN_MODE)
            state_pkg::RETURN_MODE_PREV_STATE: return_state = prev_state;
            state_pkg::RETURN_MODE_NEXT_STATE: return_state = next_state;
            // Wraps modulo the state width
            state_pkg::RETURN_MODE_DELTA:      return_state = next_state - prev_state;
            default:                           return_state = prev_state;
        endcase
    end

endmodule : state_element

`default_nettype wire

//--- design/state_table_ram.sv
`default_nettype none

module state_table_ram (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                rd_en,
    input  table_pkg::flow_id_t rd_id,
    output state_pkg::state_t   rd_state,
    input  logic                wr_en,
    input  table_pkg::flow_id_t wr_id,
    input  state_pkg::state_t   wr_state
);

    state_pkg::state_t mem [table_pkg::NUM_FLOWS];

    // Read before write on the same address
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < table_pkg::NUM_FLOWS; i++) begin
                mem[i] <= '0;
            end
            rd_state <= '0;
        end else begin
            if (wr_en) begin
                mem[wr_id] <= wr_state;
            end
            if (rd_en) begin
                rd_state <= mem[rd_id];
            end
        end
    end

endmodule : state_table_ram

`default_nettype wire

//--- design/op_arbiter.sv
`default_nettype none

module op_arbiter (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    dp_req,
    input  table_pkg::flow_id_t     dp_id,
    input  state_pkg::update_t      dp_value,
    input  logic                    dp_init,
    input  logic                    ctl_req,
    input  table_pkg::flow_id_t     ctl_id,
    input  state_pkg::update_t      ctl_value,
    input  state_pkg::update_ctxt_e ctl_ctxt,
    output logic                    dp_gnt,
    output logic                    ctl_gnt,
    output logic                    iss_valid,
    output table_pkg::src_e         iss_src,
    output table_pkg::flow_id_t     iss_id,
    output state_pkg::update_t      iss_value,
    output logic                    iss_init,
    output state_pkg::update_ctxt_e iss_ctxt
);

    // Set when control won the last granted cycle
    logic last_ctl;

    assign dp_gnt  = dp_req && (!ctl_req || last_ctl);
    assign ctl_gnt = ctl_req && !dp_gnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_ctl <= 1'b0;
        end else if (dp_gnt || ctl_gnt) begin
            last_ctl <= ctl_gnt;
        end
    end

    // Winner's fields onto the issue slot
    assign iss_valid = dp_gnt || ctl_gnt;
    assign iss_src   = ctl_gnt ? table_pkg::SRC_CONTROL : table_pkg::SRC_DATAPATH;
    assign iss_id    = ctl_gnt ? ctl_id : dp_id;
    assign iss_value = ctl_gnt ? ctl_value : dp_value;
    assign iss_init  = dp_gnt && dp_init;
    assign iss_ctxt  = ctl_gnt ? ctl_ctxt : state_pkg::UPDATE_CTXT_DATAPATH;

    a_one_grant: assert property (@(posedge clk) disable iff (!rst_n)
        !(dp_gnt && ctl_gnt));

    // Under steady contention the winner flips every cycle
    a_alternate: assert property (@(posedge clk) disable iff (!rst_n)
        (dp_req && ctl_req) ##1 (dp_req && ctl_req) |-> (dp_gnt != $past(dp_gnt)));

endmodule : op_arbiter

`default_nettype wire

//--- design/update_pipeline.sv
`default_nettype none

module update_pipeline #(
    parameter state_pkg::element_type_e ELEMENT_TYPE = state_pkg::ELEMENT_TYPE_COUNT,
    parameter state_pkg::reap_mode_e    REAP_MODE    = state_pkg::REAP_MODE_CLEAR,
    parameter state_pkg::return_mode_e  RETURN_MODE  = state_pkg::RETURN_MODE_DELTA
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    iss_valid,
    input  table_pkg::src_e         iss_src,
    input  table_pkg::flow_id_t     iss_id,
    input  state_pkg::update_t      iss_value,
    input  logic                    iss_init,
    input  state_pkg::update_ctxt_e iss_ctxt,
    output logic                    rd_en,
    output table_pkg::flow_id_t     rd_id,
    input  state_pkg::state_t       rd_state,
    output logic                    wr_en,
    output table_pkg::flow_id_t     wr_id,
    output state_pkg::state_t       wr_state,
    output logic                    res_valid,
    output table_pkg::src_e         res_src,
    output table_pkg::flow_id_t     res_id,
    output state_pkg::state_t       res_return,
    output state_pkg::state_t       res_prev
);

    logic                    s1_valid;
    table_pkg::src_e         s1_src;
    table_pkg::flow_id_t     s1_id;
    state_pkg::update_t      s1_value;
    logic                    s1_init;
    state_pkg::update_ctxt_e s1_ctxt;

    // Last write, for the read that raced it
    logic                    fwd_valid;
    table_pkg::flow_id_t     fwd_id;
    state_pkg::state_t       fwd_state;

    state_pkg::state_t       cur_state;
    state_pkg::state_t       next_state;
    state_pkg::state_t       return_state;

    // --------------------------------------------------
    // Cycle 0: issue and memory read

    assign rd_en = iss_valid;
    assign rd_id = iss_id;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid  <= 1'b0;
            fwd_valid <= 1'b0;
            res_valid <= 1'b0;
        end else begin
            s1_valid  <= iss_valid;
            fwd_valid <= wr_en;
            res_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_src     <= iss_src;
        s1_id      <= iss_id;
        s1_value   <= iss_value;
        s1_init    <= iss_init;
        s1_ctxt    <= iss_ctxt;
        fwd_id     <= wr_id;
        fwd_state  <= wr_state;
        res_src    <= s1_src;
        res_id     <= s1_id;
        res_return <= return_state;
        res_prev   <= cur_state;
    end

    // --------------------------------------------------
    // Cycle 1: forward, compute, write back

    assign cur_state = (fwd_valid && fwd_id == s1_id) ? fwd_state : rd_state;

    state_element #(
        .ELEMENT_TYPE (ELEMENT_TYPE),
        .REAP_MODE    (REAP_MODE),
        .RETURN_MODE  (RETURN_MODE)
    ) u_element (
        .ctxt         (s1_ctxt),
        .prev_state   (cur_state),
        .update       (s1_value),
        .init         (s1_init),
        .next_state   (next_state),
        .return_state (return_state)
    );

    // Plain reads leave the table untouched
    assign wr_en    = s1_valid && (s1_ctxt != state_pkg::UPDATE_CTXT_NONE);
    assign wr_id    = s1_id;
    assign wr_state = next_state;

    a_wr_after_issue: assert property (@(posedge clk) disable iff (!rst_n)
        wr_en |-> $past(iss_valid));

endmodule : update_pipeline

`default_nettype wire

//--- design/apb_state_ctrl.sv
`default_nettype none

module apb_state_ctrl (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  table_pkg::apb_addr_t    paddr,
    input  table_pkg::apb_data_t    pwdata,
    output table_pkg::apb_data_t    prdata,
    output logic                    pready,
    output logic                    pslverr,
    output logic                    ctl_req,
    output table_pkg::flow_id_t     ctl_id,
    output state_pkg::update_t      ctl_value,
    output state_pkg::update_ctxt_e ctl_ctxt,
    input  logic                    ctl_gnt,
    input  logic                    res_valid,
    input  table_pkg::src_e         res_src,
    input  state_pkg::state_t       res_prev
);

    typedef enum logic [1:0] {IDLE, REQ, WAIT, DONE} ctrl_state_e;

    ctrl_state_e             state;
    logic                    err_q;
    table_pkg::apb_data_t    rdata_q;
    table_pkg::apb_region_t  region;
    logic                    mapped;
    logic                    no_op;
    logic                    ctl_res;
    state_pkg::update_ctxt_e dec_ctxt;

    // --------------------------------------------------
    // Address decode

    assign region = paddr[table_pkg::APB_REGION_LSB +: $bits(table_pkg::apb_region_t)];
    assign mapped = (region == table_pkg::APB_REGION_STATE) ||
                    (region == table_pkg::APB_REGION_REAP);
    // Reap-region reads complete at once with zero
    assign no_op  = !mapped || (region == table_pkg::APB_REGION_REAP && !pwrite);

    always_comb begin
        dec_ctxt = state_pkg::UPDATE_CTXT_NONE;
        if (region == table_pkg::APB_REGION_REAP) begin
            dec_ctxt = state_pkg::UPDATE_CTXT_REAP;
        end else if (pwrite) begin
            dec_ctxt = state_pkg::UPDATE_CTXT_CONTROL;
        end
    end

    // Single outstanding op, so any control result is ours
    assign ctl_res = res_valid && (res_src == table_pkg::SRC_CONTROL);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            err_q <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (psel && penable) begin
                        err_q <= !mapped;
                        state <= no_op ? DONE : REQ;
                    end
                end
                REQ:     if (ctl_gnt) state <= WAIT;
                WAIT:    if (ctl_res) state <= DONE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE) begin
            ctl_id    <= table_pkg::flow_id_t'(paddr >> table_pkg::APB_ID_LSB);
            ctl_value <= state_pkg::update_t'(pwdata);
            ctl_ctxt  <= dec_ctxt;
            rdata_q   <= '0;
        end else if (state == WAIT && ctl_res && ctl_ctxt == state_pkg::UPDATE_CTXT_NONE) begin
            rdata_q <= table_pkg::apb_data_t'(res_prev);
        end
    end

    assign ctl_req = (state == REQ);
    assign pready  = (state == DONE);
    assign pslverr = (state == DONE) && err_q;
    assign prdata  = (state == DONE) ? rdata_q : '0;

    a_pready_in_access: assert property (@(posedge clk) disable iff (!rst_n)
        pready |-> psel && penable);

endmodule : apb_state_ctrl

`default_nettype wire

//--- design/flow_state_top.sv
`default_nettype none

module flow_state_top #(
    parameter state_pkg::element_type_e ELEMENT_TYPE = state_pkg::ELEMENT_TYPE_COUNT,
    parameter state_pkg::reap_mode_e    REAP_MODE    = state_pkg::REAP_MODE_CLEAR,
    parameter state_pkg::return_mode_e  RETURN_MODE  = state_pkg::RETURN_MODE_DELTA
) (
    input  logic                 clk,
    input  logic                 rst_n,
    // Datapath update port
    input  logic                 upd_valid,
    input  table_pkg::flow_id_t  upd_id,
    input  state_pkg::update_t   upd_value,
    input  logic                 upd_init,
    output logic                 upd_ready,
    output logic                 rsp_valid,
    output table_pkg::flow_id_t  rsp_id,
    output state_pkg::state_t    rsp_state,
    // APB control slave
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  table_pkg::apb_addr_t paddr,
    input  table_pkg::apb_data_t pwdata,
    output table_pkg::apb_data_t prdata,
    output logic                 pready,
    output logic                 pslverr
);

    logic                    ctl_req;
    logic                    ctl_gnt;
    table_pkg::flow_id_t     ctl_id;
    state_pkg::update_t      ctl_value;
    state_pkg::update_ctxt_e ctl_ctxt;

    logic                    iss_valid;
    table_pkg::src_e         iss_src;
    table_pkg::flow_id_t     iss_id;
    state_pkg::update_t      iss_value;
    logic                    iss_init;
    state_pkg::update_ctxt_e iss_ctxt;

    logic                    rd_en;
    table_pkg::flow_id_t     rd_id;
    state_pkg::state_t       rd_state;
    logic                    wr_en;
    table_pkg::flow_id_t     wr_id;
    state_pkg::state_t       wr_state;

    logic                    res_valid;
    table_pkg::src_e         res_src;
    table_pkg::flow_id_t     res_id;
    state_pkg::state_t       res_return;
    state_pkg::state_t       res_prev;

    op_arbiter u_arbiter (
        .clk       (clk),
        .rst_n     (rst_n),
        .dp_req    (upd_valid),
        .dp_id     (upd_id),
        .dp_value  (upd_value),
        .dp_init   (upd_init),
        .ctl_req   (ctl_req),
        .ctl_id    (ctl_id),
        .ctl_value (ctl_value),
        .ctl_ctxt  (ctl_ctxt),
        .dp_gnt    (upd_ready),
        .ctl_gnt   (ctl_gnt),
        .iss_valid (iss_valid),
        .iss_src   (iss_src),
        .iss_id    (iss_id),
        .iss_value (iss_value),
        .iss_init  (iss_init),
        .iss_ctxt  (iss_ctxt)
    );

    update_pipeline #(
        .ELEMENT_TYPE (ELEMENT_TYPE),
        .REAP_MODE    (REAP_MODE),
        .RETURN_MODE  (RETURN_MODE)
    ) u_pipeline (
        .clk        (clk),
        .rst_n      (rst_n),
        .iss_valid  (iss_valid),
        .iss_src    (iss_src),
        .iss_id     (iss_id),
        .iss_value  (iss_value),
        .iss_init   (iss_init),
        .iss_ctxt   (iss_ctxt),
        .rd_en      (rd_en),
        .rd_id      (rd_id),
        .rd_state   (rd_state),
        .wr_en      (wr_en),
        .wr_id      (wr_id),
        .wr_state   (wr_state),
        .res_valid  (res_valid),
        .res_src    (res_src),
        .res_id     (res_id),
        .res_return (res_return),
        .res_prev   (res_prev)
    );

    state_table_ram u_ram (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd_en    (rd_en),
        .rd_id    (rd_id),
        .rd_state (rd_state),
        .wr_en    (wr_en),
        .wr_id    (wr_id),
        .wr_state (wr_state)
    );

    apb_state_ctrl u_apb (
        .clk       (clk),
        .rst_n     (rst_n),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .ctl_req   (ctl_req),
        .ctl_id    (ctl_id),
        .ctl_value (ctl_value),
        .ctl_ctxt  (ctl_ctxt),
        .ctl_gnt   (ctl_gnt),
        .res_valid (res_valid),
        .res_src   (res_src),
        .res_prev  (res_prev)
    );

    // Datapath responses only
    assign rsp_valid = res_valid && (res_src == table_pkg::SRC_DATAPATH);
    assign rsp_id    = res_id;
    assign rsp_state = res_return;

endmodule : flow_state_top

`default_nettype wire

//--- sim/flow_state_model.svh
`ifndef FLOW_STATE_MODEL_SVH
`define FLOW_STATE_MODEL_SVH

`default_nettype none

// Element configuration shared by the model and the DUT
localparam state_pkg::element_type_e MODEL_ELEMENT = state_pkg::ELEMENT_TYPE_COUNT;
localparam state_pkg::reap_mode_e    MODEL_REAP    = state_pkg::REAP_MODE_CLEAR;
localparam state_pkg::return_mode_e  MODEL_RETURN  = state_pkg::RETURN_MODE_DELTA;

state_pkg::state_t model_mem [table_pkg::NUM_FLOWS];

// Expected datapath responses, oldest first
table_pkg::flow_id_t exp_id_q [$];
state_pkg::state_t   exp_state_q [$];
int unsigned         exp_due_q [$];

function automatic void clear_model();
    foreach (model_mem[i]) begin
        model_mem[i] = '0;
    end
    exp_id_q.delete();
    exp_state_q.delete();
    exp_due_q.delete();
endfunction

// Updates one flow and gives back the reported value
function automatic state_pkg::state_t apply_rules(input state_pkg::update_ctxt_e ctxt,
                                                  input table_pkg::flow_id_t id,
                                                  input state_pkg::update_t value,
                                                  input logic init);
    state_pkg::state_t prev;
    state_pkg::state_t next;
    prev = model_mem[id];
    next = prev;
    if (ctxt == state_pkg::UPDATE_CTXT_DATAPATH) begin
        case (MODEL_ELEMENT)
            state_pkg::ELEMENT_TYPE_WRITE:   next = value;
            state_pkg::ELEMENT_TYPE_FLAGS:   next = init ? value : (prev | value);
            state_pkg::ELEMENT_TYPE_COUNTER: next = init ? 16'd1 : prev + 16'd1;
            default:                         next = init ? value : prev + value;
        endcase
    end else if (ctxt == state_pkg::UPDATE_CTXT_CONTROL) begin
        next = value;
    end else if (ctxt == state_pkg::UPDATE_CTXT_REAP) begin
        case (MODEL_REAP)
            state_pkg::REAP_MODE_CLEAR:   next = '0;
            state_pkg::REAP_MODE_PERSIST: next = prev;
            default:                      next = value;
        endcase
    end
    model_mem[id] = next;
    case (MODEL_RETURN)
        state_pkg::RETURN_MODE_PREV_STATE: return prev;
        state_pkg::RETURN_MODE_NEXT_STATE: return next;
        default:                           return next - prev;
    endcase
endfunction

function automatic void record_event(input table_pkg::flow_id_t id,
                                     input state_pkg::update_t value,
                                     input logic init,
                                     input int unsigned due);
    exp_id_q.push_back(id);
    exp_state_q.push_back(apply_rules(state_pkg::UPDATE_CTXT_DATAPATH, id, value, init));
    exp_due_q.push_back(due);
endfunction

`default_nettype wire

`endif

//--- sim/tb_flow_state.sv
`include "flow_state_model.svh"

`default_nettype none

module tb_flow_state;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF_PERIOD = 20;
    localparam int APB_TIMEOUT = 40;
    localparam int STALL_LIMIT = 16;
    localparam int DRAIN_LIMIT = 20;

    logic                 clk;
    logic                 rst_n;
    logic                 upd_valid;
    table_pkg::flow_id_t  upd_id;
    state_pkg::update_t   upd_value;
    logic                 upd_init;
    logic                 upd_ready;
    logic                 rsp_valid;
    table_pkg::flow_id_t  rsp_id;
    state_pkg::state_t    rsp_state;
    logic                 psel;
    logic                 penable;
    logic                 pwrite;
    table_pkg::apb_addr_t paddr;
    table_pkg::apb_data_t pwdata;
    table_pkg::apb_data_t prdata;
    logic                 pready;
    logic                 pslverr;

    integer      seed;
    int          errors = 0;
    int          checks = 0;
    int          stalls = 0;
    int unsigned cycle = 0;

    flow_state_top #(
        .ELEMENT_TYPE (MODEL_ELEMENT),
        .REAP_MODE    (MODEL_REAP),
        .RETURN_MODE  (MODEL_RETURN)
    ) dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .upd_valid (upd_valid),
        .upd_id    (upd_id),
        .upd_value (upd_value),
        .upd_init  (upd_init),
        .upd_ready (upd_ready),
        .rsp_valid (rsp_valid),
        .rsp_id    (rsp_id),
        .rsp_state (rsp_state),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // --------------------------------------------------
    // Checks and end of run

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("ERR %0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
        end
    endtask

    task automatic check_true(input logic ok, input string what);
        checks++;
        assert (ok) else begin
            errors++;
            $display("%0t %s", $time, what);
        end
    endtask

    task automatic end_run();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    endtask

    task automatic give_up(input string what);
        errors++;
        $display("%0t %s", $time, what);
        end_run();
    endtask

    function automatic int unsigned pick(input int unsigned span);
        return $unsigned($random(seed)) % span;
    endfunction

    // --------------------------------------------------
    // Datapath port

    task automatic drive_event(input int base, input int span, input bit gaps);
        upd_valid = !gaps || (pick(4) != 0);
        upd_id    = table_pkg::flow_id_t'(base + pick(span));
        upd_value = state_pkg::update_t'($random(seed));
        upd_init  = (pick(8) == 0);
    endtask

    task automatic send_events(input int count, input int base, input int span, input bit gaps);
        int sent;
        int stall;
        bit taken;
        sent  = 0;
        stall = 0;
        @(negedge clk);
        drive_event(base, span, gaps);
        while (sent < count) begin
            taken = 1'b0;
            #(HALF_PERIOD - 1);
            if (upd_valid && upd_ready) begin
                // Accepted on the coming edge, response due two cycles on
                record_event(upd_id, upd_value, upd_init, cycle + 2);
                taken = 1'b1;
                sent++;
                stall = 0;
            end else if (upd_valid) begin
                stall++;
                stalls++;
                if (stall > STALL_LIMIT) begin
                    give_up("Datapath event held without upd_ready for too long");
                end
            end
            @(negedge clk);
            if (sent == count) begin
                upd_valid = 1'b0;
            end else if (taken || !upd_valid) begin
                drive_event(base, span, gaps);
            end
        end
    endtask

    initial begin
        forever begin
            @(negedge clk);
            if (rsp_valid) begin
                check_true(exp_id_q.size() != 0, "Datapath response with no event pending");
                if (exp_id_q.size() != 0) begin
                    check_value("rsp_id", 32'(rsp_id), 32'(exp_id_q.pop_front()));
                    check_value("rsp_state", 32'(rsp_state), 32'(exp_state_q.pop_front()));
                    check_value("rsp_valid cycle", cycle, exp_due_q.pop_front());
                end
            end else if (exp_due_q.size() != 0) begin
                check_true(exp_due_q[0] > cycle, "Datapath response missing at its due cycle");
                if (exp_due_q[0] <= cycle) begin
                    void'(exp_id_q.pop_front());
                    void'(exp_state_q.pop_front());
                    void'(exp_due_q.pop_front());
                end
            end
        end
    end

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_id_q.size() != 0) begin
            @(negedge clk);
            waited++;
            if (waited > DRAIN_LIMIT) begin
                give_up("Datapath responses did not drain");
            end
        end
    endtask

    // --------------------------------------------------
    // APB control port

    task automatic apb_access(input logic write, input table_pkg::apb_addr_t addr,
                              input table_pkg::apb_data_t wdata,
                              output table_pkg::apb_data_t rdata, output logic err);
        int waited;
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        waited  = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > APB_TIMEOUT) begin
                give_up("APB access never saw pready");
            end
        end while (!pready);
        rdata = prdata;
        err   = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic read_state(input int id);
        table_pkg::apb_data_t rdata;
        logic                 err;
        apb_access(1'b0, {2'b00, table_pkg::flow_id_t'(id), 2'b00}, '0, rdata, err);
        check_value("prdata", rdata, 32'(model_mem[id]));
        check_value("pslverr", 32'(err), 32'd0);
    endtask

    task automatic write_state(input int id, input state_pkg::update_t value);
        table_pkg::apb_data_t rdata;
        logic                 err;
        apb_access(1'b1, {2'b00, table_pkg::flow_id_t'(id), 2'b00}, 32'(value), rdata, err);
        void'(apply_rules(state_pkg::UPDATE_CTXT_CONTROL, table_pkg::flow_id_t'(id), value, 1'b0));
        check_value("pslverr", 32'(err), 32'd0);
    endtask

    task automatic reap_flow(input int id);
        table_pkg::apb_data_t rdata;
        table_pkg::apb_data_t wdata;
        logic                 err;
        wdata = $random(seed);
        apb_access(1'b1, {2'b01, table_pkg::flow_id_t'(id), 2'b00}, wdata, rdata, err);
        void'(apply_rules(state_pkg::UPDATE_CTXT_REAP, table_pkg::flow_id_t'(id),
                          state_pkg::update_t'(wdata), 1'b0));
        check_value("pslverr", 32'(err), 32'd0);
        // Reap region reads as zero
        apb_access(1'b0, {2'b01, table_pkg::flow_id_t'(id), 2'b00}, '0, rdata, err);
        check_value("prdata", rdata, 32'd0);
    endtask

    task automatic access_unmapped();
        table_pkg::apb_data_t rdata;
        logic                 err;
        apb_access(pick(2) != 0, {1'b1, 11'(pick(2048))}, $random(seed), rdata, err);
        check_value("pslverr", 32'(err), 32'd1);
    endtask

    // --------------------------------------------------
    // Test sequence

    initial begin
        seed      = 32'h32c7_3b24;
        rst_n     = 1'b0;
        upd_valid = 1'b0;
        upd_id    = '0;
        upd_value = '0;
        upd_init  = 1'b0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        clear_model();
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (int i = 0; i < 8; i++) begin
            read_state(pick(table_pkg::NUM_FLOWS));
        end

        // Random events, ids narrowed to force collisions
        send_events(80, 0, 8, 1'b1);
        wait_drain();

        // Back-to-back on one flow exercises forwarding
        send_events(24, 5, 1, 1'b0);
        wait_drain();

        write_state(3, state_pkg::update_t'($random(seed)));
        read_state(3);
        send_events(12, 3, 1, 1'b0);
        wait_drain();
        read_state(3);

        reap_flow(3);
        read_state(3);
        access_unmapped();
        for (int i = 0; i < 8; i++) begin
            read_state(i);
        end

        // Control traffic on other flows against a busy datapath
        stalls = 0;
        fork
            send_events(200, 0, 8, 1'b0);
            begin
                for (int i = 0; i < 12; i++) begin
                    case (pick(3))
                        0:       read_state(16 + pick(8));
                        1:       write_state(16 + pick(8), state_pkg::update_t'($random(seed)));
                        default: reap_flow(16 + pick(8));
                    endcase
                end
            end
        join
        wait_drain();
        check_true(stalls > 0, "No upd_ready back-pressure seen under APB traffic");
        for (int i = 0; i < 24; i++) begin
            read_state(i);
        end
        end_run();
    end

endmodule : tb_flow_state

`default_nettype wire

//--- flow_state.f
+incdir+sim
design/state_pkg.sv
design/table_pkg.sv
design/state_element.sv
design/state_table_ram.sv
design/op_arbiter.sv
design/update_pipeline.sv
design/apb_state_ctrl.sv
design/flow_state_top.sv
sim/tb_flow_state.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_flow_state
FILELIST  ?= flow_state.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

# Pass only when the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "No errors" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
